/* exc_unit.f */
rtl/exc_pkg.sv
rtl/exc_controller.sv
rtl/exc_pipe_ctrl.sv
rtl/exc_csr.sv
rtl/exc_pc_sel.sv
rtl/exc_unit_top.sv
test/exc_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the exception-entry testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f exc_unit.f --top-module exc_unit_tb \
  -o exc_unit_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/exc_unit_sim > sim.log 2>&1

grep -q "No errors" sim.log && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }

/* test/exc_unit_tb.sv */
/*
  Testbench for the exception-entry path.
  Drives synchronous events, interrupt lines, debug settings, eret and
  random stalls into the top level. Reference models of priority, cause
  codes, handler targets and mie/mpie run beside the DUT, and concurrent
  assertions sampled on the falling edge compare the two.
*/

`timescale 1ns/100ps

module exc_unit_tb;

  localparam exc_pkg::addr_t EXC_BASE_TB = 32'h0000_1000;
  localparam exc_pkg::addr_t VEC_BASE_TB = 32'h0000_2000;

  logic               clk;
  logic               rst_n;
  exc_pkg::irq_t      irq_i;
  logic               ebrk_i;
  logic               illegal_i;
  logic               ecall_i;
  logic               load_err_i;
  logic               store_err_i;
  logic               eret_i;
  logic               mie_set_i;
  exc_pkg::addr_t     pc_i;
  logic               stall_i;
  exc_pkg::dbg_sets_t dbg_settings_i;
  logic               trap_o;
  logic               exc_taken_o;
  exc_pkg::cause_t    cause_o;
  exc_pkg::addr_t     mepc_o;
  logic               irq_enable_o;
  logic               jump_o;
  exc_pkg::addr_t     jump_pc_o;

  logic               stall_en;

  exc_unit_top #(
    .EXC_BASE (EXC_BASE_TB),
    .VEC_BASE (VEC_BASE_TB)
  ) exc_unit_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .ebrk_i         (ebrk_i),
    .illegal_i      (illegal_i),
    .ecall_i        (ecall_i),
    .load_err_i     (load_err_i),
    .store_err_i    (store_err_i),
    .eret_i         (eret_i),
    .mie_set_i      (mie_set_i),
    .pc_i           (pc_i),
    .stall_i        (stall_i),
    .dbg_settings_i (dbg_settings_i),
    .trap_o         (trap_o),
    .exc_taken_o    (exc_taken_o),
    .cause_o        (cause_o),
    .mepc_o         (mepc_o),
    .irq_enable_o   (irq_enable_o),
    .jump_o         (jump_o),
    .jump_pc_o      (jump_pc_o)
  );

  //////////////////////////////////////////////////
  // clock and stall generation
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // back-pressure changes every cycle once enabled
  initial begin
    stall_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      stall_i = stall_en && ($urandom_range(2) == 0);
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  logic             exp_req;
  logic             exp_trap;
  logic             exp_entry;
  logic             irq_live;
  exc_pkg::cause_t  exp_cause;
  exc_pkg::pc_mux_t exp_class;

  logic             phase_m;
  logic             mie_m;
  logic             mpie_m;
  logic             jump_m;
  exc_pkg::cause_t  mcause_m;
  exc_pkg::cause_t  cap_cause_m;
  exc_pkg::pc_mux_t cap_class_m;
  exc_pkg::addr_t   cap_pc_m;
  exc_pkg::addr_t   mepc_m;
  exc_pkg::addr_t   tgt_m;

  // interrupts count only while enabled
  assign irq_live = mie_m & (|irq_i);

  always_comb begin
    exp_trap = dbg_settings_i[exc_pkg::DBG_SETS_SSTE]
             | (ebrk_i & dbg_settings_i[exc_pkg::DBG_SETS_EBRK])
             | (ecall_i & dbg_settings_i[exc_pkg::DBG_SETS_ECALL])
             | (illegal_i & dbg_settings_i[exc_pkg::DBG_SETS_EILL])
             | ((load_err_i | store_err_i) & dbg_settings_i[exc_pkg::DBG_SETS_ELSU])
             | (irq_live & dbg_settings_i[exc_pkg::DBG_SETS_IRQ]);
  end

  // priority list, highest first
  always_comb begin
    exp_req   = 1'b1;
    exp_cause = '0;
    exp_class = exc_pkg::EXC_PC_IRQ;
    if (store_err_i && !dbg_settings_i[exc_pkg::DBG_SETS_ELSU]) begin
      exp_cause = exc_pkg::CAUSE_STORE_ERR;
      exp_class = exc_pkg::EXC_PC_LSU;
    end else if (load_err_i && !dbg_settings_i[exc_pkg::DBG_SETS_ELSU]) begin
      exp_cause = exc_pkg::CAUSE_LOAD_ERR;
      exp_class = exc_pkg::EXC_PC_LSU;
    end else if (illegal_i && !dbg_settings_i[exc_pkg::DBG_SETS_EILL]) begin
      exp_cause = exc_pkg::CAUSE_ILLEGAL;
      exp_class = exc_pkg::EXC_PC_ILLINSN;
    end else if (ecall_i && !dbg_settings_i[exc_pkg::DBG_SETS_ECALL]) begin
      exp_cause = exc_pkg::CAUSE_ECALL;
      exp_class = exc_pkg::EXC_PC_ECALL;
    end else if (irq_live && !dbg_settings_i[exc_pkg::DBG_SETS_IRQ]) begin
      // lowest set line wins
      for (int i = 31; i >= 0; i--) begin
        if (irq_i[i]) begin
          exp_cause = {1'b1, 5'(i)};
        end
      end
    end else begin
      exp_req = 1'b0;
    end
  end

  // entry after the drain cycle, in the first unstalled cycle
  assign exp_entry = phase_m & ~stall_i;

  function automatic exc_pkg::addr_t handler_pc(input exc_pkg::cause_t c,
                                                input exc_pkg::pc_mux_t m);
    if (c[5]) begin
      return VEC_BASE_TB + 32'(c[4:0]) * 32'd4;
    end
    return EXC_BASE_TB + 32'(m) * exc_pkg::addr_t'(exc_pkg::PC_MUX_OFFSET_STEP);
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_m     <= 1'b0;
      mie_m       <= 1'b0;
      mpie_m      <= 1'b0;
      jump_m      <= 1'b0;
      mcause_m    <= '0;
      cap_cause_m <= '0;
      cap_class_m <= exc_pkg::EXC_PC_IRQ;
      cap_pc_m    <= '0;
      mepc_m      <= '0;
      tgt_m       <= '0;
    end else begin
      jump_m <= exp_entry | eret_i;
      if (exp_entry) begin
        tgt_m <= handler_pc(cap_cause_m, cap_class_m);
      end else if (eret_i) begin
        tgt_m <= mepc_m;
      end
      // cause and pc frozen in the first request cycle
      if (!phase_m && exp_req) begin
        phase_m     <= 1'b1;
        cap_cause_m <= exp_cause;
        cap_class_m <= exp_class;
        cap_pc_m    <= pc_i;
      end else if (exp_entry) begin
        phase_m <= 1'b0;
      end
      if (exp_entry) begin
        mpie_m   <= mie_m;
        mie_m    <= 1'b0;
        mcause_m <= cap_cause_m;
        mepc_m   <= cap_pc_m;
      end else if (eret_i) begin
        mie_m <= mpie_m;
      end else if (mie_set_i) begin
        mie_m <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, act_v);
    stop_on_error();
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    stop_on_error();
  endtask

  task automatic report_unexpected(input string what);
    $display("unexpected event at %0t: %s", $time, what);
    stop_on_error();
  endtask

  // falling edge, all outputs and inputs settled
  a_taken: assert property (@(negedge clk) exc_taken_o == exp_entry)
    else report_mismatch("exc_taken_o", 32'(exp_entry), 32'(exc_taken_o));
  a_trap: assert property (@(negedge clk) trap_o == exp_trap)
    else report_mismatch("trap_o", 32'(exp_trap), 32'(trap_o));
  a_cause: assert property (@(negedge clk) cause_o == mcause_m)
    else report_mismatch("cause_o", 32'(mcause_m), 32'(cause_o));
  a_mepc: assert property (@(negedge clk) mepc_o == mepc_m)
    else report_mismatch("mepc_o", mepc_m, mepc_o);
  a_mie: assert property (@(negedge clk) irq_enable_o == mie_m)
    else report_mismatch("irq_enable_o", 32'(mie_m), 32'(irq_enable_o));
  a_jump: assert property (@(negedge clk) jump_o == jump_m)
    else report_mismatch("jump_o", 32'(jump_m), 32'(jump_o));
  a_jump_pc: assert property (@(negedge clk) jump_o |-> (jump_pc_o == tgt_m))
    else report_mismatch("jump_pc_o", tgt_m, jump_pc_o);

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_events();
    irq_i       = '0;
    ebrk_i      = 1'b0;
    illegal_i   = 1'b0;
    ecall_i     = 1'b0;
    load_err_i  = 1'b0;
    store_err_i = 1'b0;
  endtask

  // events stay up until the entry cycle, then drop
  task automatic wait_for_entry(input int unsigned limit);
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (!exc_taken_o && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!exc_taken_o) begin
      report_timeout("no exception entry after a request");
    end
    next_cycle();
    clear_events();
  endtask

  task automatic expect_no_entry(input int unsigned cycles);
    int unsigned n;
    n = 0;
    while (n < cycles) begin
      @(negedge clk);
      if (exc_taken_o) begin
        report_unexpected("exception entry for an event sent to debug");
      end
      n++;
    end
    next_cycle();
  endtask

  task automatic pulse_eret();
    eret_i = 1'b1;
    next_cycle();
    eret_i = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic drive_sync(input logic [3:0] ev);
    pc_i        = $urandom;
    ecall_i     = ev[0];
    illegal_i   = ev[1];
    load_err_i  = ev[2];
    store_err_i = ev[3];
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned sel;
    int unsigned kind;
    void'($urandom(44762));
    rst_n          = 1'b0;
    stall_en       = 1'b0;
    eret_i         = 1'b0;
    mie_set_i      = 1'b0;
    pc_i           = '0;
    dbg_settings_i = '0;
    clear_events();

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) next_cycle();
    stall_en = 1'b1;

    // synchronous events, single and combined, mie stays low
    repeat (16) begin
      drive_sync(4'($urandom_range(15, 1)));
      wait_for_entry(60);
      next_cycle();
      pulse_eret();
    end

    // masked lines must not request
    irq_i = 32'h0000_0110;
    repeat (6) next_cycle();
    mie_set_i = 1'b1;
    next_cycle();
    mie_set_i = 1'b0;
    wait_for_entry(60);
    next_cycle();
    pulse_eret();

    // interrupts, sometimes beaten by a synchronous event
    repeat (16) begin
      sel   = $urandom_range(31);
      irq_i = ($urandom | 32'h1) << sel;
      if ($urandom_range(3) == 0) begin
        drive_sync(4'($urandom_range(15, 1)));
      end
      wait_for_entry(60);
      next_cycle();
      pulse_eret();
    end

    // debug-redirected events, one cycle each
    stall_en = 1'b0;
    repeat (20) begin
      kind           = $urandom_range(5);
      dbg_settings_i = 6'(1) << kind;
      if ($urandom_range(1) == 0) begin
        dbg_settings_i = dbg_settings_i | exc_pkg::dbg_sets_t'(1 << exc_pkg::DBG_SETS_SSTE);
      end
      case (kind)
        exc_pkg::DBG_SETS_IRQ:   irq_i = 32'h1 << $urandom_range(31);
        exc_pkg::DBG_SETS_ECALL: ecall_i = 1'b1;
        exc_pkg::DBG_SETS_EILL:  illegal_i = 1'b1;
        exc_pkg::DBG_SETS_ELSU: begin
          // load and store errors share one debug bit
          if ($urandom_range(1) == 0) begin
            load_err_i = 1'b1;
          end else begin
            store_err_i = 1'b1;
          end
        end
        exc_pkg::DBG_SETS_EBRK:  ebrk_i = 1'b1;
        // single step with a plain ebreak beside it
        default:                 ebrk_i = 1'b1;
      endcase
      next_cycle();
      clear_events();
      dbg_settings_i = '0;
      expect_no_entry(10);
    end

    // ebreak without its debug bit does nothing at all
    ebrk_i = 1'b1;
    next_cycle();
    ebrk_i = 1'b0;
    expect_no_entry(10);

    $display("No errors");
    $finish;
  end

endmodule

/* rtl/exc_unit_top.sv */
/*
  Exception-entry path top level.
  Connects the exception controller, the core-side controller, the
  CSR block and the PC selector, and passes the handler table bases
  down to the PC selector.
*/

`timescale 1ns/100ps

module exc_unit_top #(
  parameter exc_pkg::addr_t EXC_BASE = 32'h0000_0100,
  parameter exc_pkg::addr_t VEC_BASE = 32'h0000_0200
) (
  input  logic               clk,
  input  logic               rst_n,

  // events
  input  exc_pkg::irq_t      irq_i,
  input  logic               ebrk_i,
  input  logic               illegal_i,
  input  logic               ecall_i,
  input  logic               load_err_i,
  input  logic               store_err_i,
  input  logic               eret_i,
  input  logic               mie_set_i,
  input  exc_pkg::addr_t     pc_i,
  input  logic               stall_i,
  input  exc_pkg::dbg_sets_t dbg_settings_i,

  // results
  output logic               trap_o,
  output logic               exc_taken_o,
  output exc_pkg::cause_t    cause_o,
  output exc_pkg::addr_t     mepc_o,
  output logic               irq_enable_o,
  output logic               jump_o,
  output exc_pkg::addr_t     jump_pc_o
);

  logic             req;
  logic             ack;
  logic             save_cause;
  logic             irq_enable;
  exc_pkg::cause_t  cause;
  exc_pkg::pc_mux_t pc_mux;
  logic [4:0]       vec_idx;

  //////////////////////////////////////////////////
  // cause selection and handshake
  //////////////////////////////////////////////////

  exc_controller exc_controller_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_o          (req),
    .ack_i          (ack),
    .trap_o         (trap_o),
    .pc_mux_o       (pc_mux),
    .vec_idx_o      (vec_idx),
    .irq_i          (irq_i),
    .irq_enable_i   (irq_enable),
    .ebrk_i         (ebrk_i),
    .illegal_i      (illegal_i),
    .ecall_i        (ecall_i),
    .load_err_i     (load_err_i),
    .store_err_i    (store_err_i),
    .cause_o        (cause),
    .save_cause_o   (save_cause),
    .dbg_settings_i (dbg_settings_i)
  );

  exc_pipe_ctrl exc_pipe_ctrl_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (req),
    .stall_i (stall_i),
    .ack_o   (ack)
  );

  //////////////////////////////////////////////////
  // state update and redirect
  //////////////////////////////////////////////////

  exc_csr exc_csr_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .save_cause_i (save_cause),
    .cause_i      (cause),
    .pc_i         (pc_i),
    .eret_i       (eret_i),
    .mie_set_i    (mie_set_i),
    .irq_enable_o (irq_enable),
    .mcause_o     (cause_o),
    .mepc_o       (mepc_o)
  );

  // interrupt flag is bit 5 of the selected cause
  exc_pc_sel #(
    .EXC_BASE (EXC_BASE),
    .VEC_BASE (VEC_BASE)
  ) exc_pc_sel_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .save_cause_i (save_cause),
    .pc_mux_i     (pc_mux),
    .vec_idx_i    (vec_idx),
    .is_irq_i     (cause[5]),
    .eret_i       (eret_i),
    .mepc_i       (mepc_o),
    .jump_o       (jump_o),
    .jump_pc_o    (jump_pc_o)
  );

  assign exc_taken_o  = save_cause;
  assign irq_enable_o = irq_enable;

endmodule

/* rtl/exc_pc_sel.sv */
/*
  Redirect PC for exception entry and return.
  Interrupts jump into the vector table, other causes into the handler
  table slot of their class, and eret back to the saved PC. The target
  is registered together with a one-cycle jump pulse.
*/

`timescale 1ns/100ps

module exc_pc_sel #(
  parameter exc_pkg::addr_t EXC_BASE = 32'h0000_0100,
  parameter exc_pkg::addr_t VEC_BASE = 32'h0000_0200
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             save_cause_i,
  input  exc_pkg::pc_mux_t pc_mux_i,
  input  logic [4:0]       vec_idx_i,
  input  logic             is_irq_i,

  input  logic             eret_i,
  input  exc_pkg::addr_t   mepc_i,

  output logic             jump_o,
  output exc_pkg::addr_t   jump_pc_o
);

  exc_pkg::addr_t target_pc;
  logic           jump_d;

  assign jump_d = save_cause_i | eret_i;

  // one word per vector, one slot per handler class
  always_comb begin
    if (eret_i) begin
      target_pc = mepc_i;
    end else if (is_irq_i) begin
      target_pc = VEC_BASE + {25'd0, vec_idx_i, 2'b00};
    end else begin
      target_pc = EXC_BASE
                + exc_pkg::addr_t'(pc_mux_i) * exc_pkg::addr_t'(exc_pkg::PC_MUX_OFFSET_STEP);
    end
  end

  // target and pulse leave together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      jump_o    <= 1'b0;
      jump_pc_o <= '0;
    end else begin
      jump_o <= jump_d;
      if (jump_d) begin
        jump_pc_o <= target_pc;
      end
    end
  end

endmodule

/* rtl/exc_csr.sv */
/*
  Machine-mode exception registers.
  Keeps the interrupt enable and its saved copy, the cause and the
  exception PC. Entry saves the cause and PC and masks interrupts,
  eret brings the enable back, and a set pulse enables interrupts.
  All updates land one clock after the request.
*/

`timescale 1ns/100ps

module exc_csr (
  input  logic            clk,
  input  logic            rst_n,

  // entry from the exception controller
  input  logic            save_cause_i,
  input  exc_pkg::cause_t cause_i,
  // PC of the excepting instruction
  input  exc_pkg::addr_t  pc_i,

  // return from handler
  input  logic            eret_i,

  // software enable of interrupts
  input  logic            mie_set_i,

  output logic            irq_enable_o,
  output exc_pkg::cause_t mcause_o,
  output exc_pkg::addr_t  mepc_o
);

  logic            mie_q;
  logic            mpie_q;
  exc_pkg::cause_t mcause_q;
  exc_pkg::addr_t  mepc_q;

  //////////////////////////////////////////////////
  // status bits
  //////////////////////////////////////////////////

  // entry wins over eret and the set pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
    end else if (save_cause_i) begin
      // remember the enable, mask while in the handler
      mpie_q <= mie_q;
      mie_q  <= 1'b0;
    end else if (eret_i) begin
      mie_q  <= mpie_q;
    end else if (mie_set_i) begin
      mie_q  <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // cause and exception PC
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcause_q <= '0;
      mepc_q   <= '0;
    end else if (save_cause_i) begin
      mcause_q <= cause_i;
      mepc_q   <= pc_i;
    end
  end

  assign irq_enable_o = mie_q;
  assign mcause_o     = mcause_q;
  assign mepc_o       = mepc_q;

endmodule

/* rtl/exc_pipe_ctrl.sv */
/*
  Core-side controller for exception entry.
  On a new request the pipeline is drained for one cycle, then the
  controller waits until the pipeline is no longer stalled and answers
  with an acknowledge. The acknowledge ends the entry.
*/

`timescale 1ns/100ps

module exc_pipe_ctrl (
  input  logic clk,
  input  logic rst_n,

  // request from the exception controller
  input  logic req_i,

  // pipeline back-pressure
  input  logic stall_i,

  output logic ack_o
);

  typedef enum logic [1:0] {
    RUN,
    DRAIN,
    WAIT_UNSTALL
  } pipe_state_t;

  pipe_state_t state_q;
  pipe_state_t state_d;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ack_o   = 1'b0;

    unique case (state_q)
      // first request cycle flushes the pipe, no ack yet
      RUN: begin
        if (req_i) begin
          state_d = DRAIN;
        end
      end

      // drain done, take the entry unless stalled
      DRAIN: begin
        if (!req_i) begin
          state_d = RUN;
        end else if (!stall_i) begin
          ack_o   = 1'b1;
          state_d = RUN;
        end else begin
          state_d = WAIT_UNSTALL;
        end
      end

      // stalled, the request stays parked here
      WAIT_UNSTALL: begin
        if (!req_i) begin
          state_d = RUN;
        end else if (!stall_i) begin
          ack_o   = 1'b1;
          state_d = RUN;
        end
      end

      default: state_d = RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* rtl/exc_controller.sv */
/*
  Exception controller.
  Picks one cause out of the synchronous events and the interrupt lines,
  sends debug-redirected events to the debug side as a trap and requests
  exception entry from the core controller for the rest. The cause and
  handler class are bypassed in the first request cycle and held in
  registers until the acknowledge arrives.
*/

`timescale 1ns/100ps

module exc_controller (
  input  logic               clk,
  input  logic               rst_n,

  // request/acknowledge pair towards the core controller
  output logic               req_o,
  input  logic               ack_i,

  // to the debug side
  output logic               trap_o,

  // to the PC selector
  output exc_pkg::pc_mux_t   pc_mux_o,
  output logic [4:0]         vec_idx_o,

  // level interrupt lines and global enable
  input  exc_pkg::irq_t      irq_i,
  input  logic               irq_enable_i,

  // synchronous events from decoder and load/store unit
  input  logic               ebrk_i,
  input  logic               illegal_i,
  input  logic               ecall_i,
  input  logic               load_err_i,
  input  logic               store_err_i,

  // to the CSR block
  output exc_pkg::cause_t    cause_o,
  output logic               save_cause_o,

  input  exc_pkg::dbg_sets_t dbg_settings_i
);

  typedef enum logic [0:0] {
    IDLE,
    WAIT_CTRL
  } exc_state_t;

  exc_state_t       state_q;
  exc_state_t       state_d;

  logic             irq_pending;
  logic             req_int;
  logic             first_req;

  exc_pkg::cause_t  cause_int;
  exc_pkg::cause_t  cause_q;
  exc_pkg::pc_mux_t pc_mux_int;
  exc_pkg::pc_mux_t pc_mux_q;

  //////////////////////////////////////////////////
  // debug redirection and request
  //////////////////////////////////////////////////

  // interrupts only count while enabled and not owned by debug
  assign irq_pending = irq_enable_i & (|irq_i) & ~dbg_settings_i[exc_pkg::DBG_SETS_IRQ];

  // single step traps every cycle, ebreak only ever goes to debug
  assign trap_o = dbg_settings_i[exc_pkg::DBG_SETS_SSTE]
                | (ebrk_i      & dbg_settings_i[exc_pkg::DBG_SETS_EBRK])
                | (ecall_i     & dbg_settings_i[exc_pkg::DBG_SETS_ECALL])
                | (illegal_i   & dbg_settings_i[exc_pkg::DBG_SETS_EILL])
                | (load_err_i  & dbg_settings_i[exc_pkg::DBG_SETS_ELSU])
                | (store_err_i & dbg_settings_i[exc_pkg::DBG_SETS_ELSU])
                | (irq_enable_i & (|irq_i) & dbg_settings_i[exc_pkg::DBG_SETS_IRQ]);

  assign req_int = (ecall_i     & ~dbg_settings_i[exc_pkg::DBG_SETS_ECALL])
                 | (illegal_i   & ~dbg_settings_i[exc_pkg::DBG_SETS_EILL])
                 | (load_err_i  & ~dbg_settings_i[exc_pkg::DBG_SETS_ELSU])
                 | (store_err_i & ~dbg_settings_i[exc_pkg::DBG_SETS_ELSU])
                 | irq_pending;

  //////////////////////////////////////////////////
  // cause selection
  //////////////////////////////////////////////////

  // later assignments win, so the lowest priority comes first
  always_comb begin
    cause_int  = '0;
    pc_mux_int = exc_pkg::EXC_PC_IRQ;

    if (irq_pending) begin
      // walk downwards so the lowest set line is the last one kept
      for (int i = $bits(exc_pkg::irq_t) - 1; i >= 0; i--) begin
        if (irq_i[i]) begin
          cause_int = {1'b1, 5'(i)};
        end
      end
    end

    if (ecall_i & ~dbg_settings_i[exc_pkg::DBG_SETS_ECALL]) begin
      cause_int  = exc_pkg::CAUSE_ECALL;
      pc_mux_int = exc_pkg::EXC_PC_ECALL;
    end

    if (illegal_i & ~dbg_settings_i[exc_pkg::DBG_SETS_EILL]) begin
      cause_int  = exc_pkg::CAUSE_ILLEGAL;
      pc_mux_int = exc_pkg::EXC_PC_ILLINSN;
    end

    if (load_err_i & ~dbg_settings_i[exc_pkg::DBG_SETS_ELSU]) begin
      cause_int  = exc_pkg::CAUSE_LOAD_ERR;
      pc_mux_int = exc_pkg::EXC_PC_LSU;
    end

    if (store_err_i & ~dbg_settings_i[exc_pkg::DBG_SETS_ELSU]) begin
      cause_int  = exc_pkg::CAUSE_STORE_ERR;
      pc_mux_int = exc_pkg::EXC_PC_LSU;
    end
  end

  assign first_req = (state_q == IDLE) & req_int;

  // capture once, then hold for the whole wait
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cause_q  <= '0;
      pc_mux_q <= exc_pkg::EXC_PC_IRQ;
    end else if (first_req) begin
      cause_q  <= cause_int;
      pc_mux_q <= pc_mux_int;
    end
  end

  // bypass in the first request cycle
  assign cause_o   = first_req ? cause_int  : cause_q;
  assign pc_mux_o  = first_req ? pc_mux_int : pc_mux_q;
  assign vec_idx_o = cause_o[4:0];

  //////////////////////////////////////////////////
  // handshake FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    req_o        = 1'b0;
    save_cause_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        req_o = req_int;
        if (req_int) begin
          // ack in the same cycle closes the entry at once
          if (ack_i) begin
            save_cause_o = 1'b1;
          end else begin
            state_d = WAIT_CTRL;
          end
        end
      end

      WAIT_CTRL: begin
        req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* rtl/exc_pkg.sv */
/*
  Shared definitions for the exception-entry path.
  Holds the widths that carry a meaning, the exception cause codes,
  the handler classes that drive the PC selector and the bit positions
  inside the debug setting word. Every RTL block refers to these by
  scoped names.
*/

package exc_pkg;

  //////////////////////////////////////////////////
  // widths and types
  //////////////////////////////////////////////////

  localparam int unsigned DBG_SETS_W = 6;

  // bit 5 set means interrupt, bits 4..0 are code or line index
  typedef logic [5:0]            cause_t;
  // handler class, one 16-byte slot each
  typedef logic [1:0]            pc_mux_t;
  typedef logic [31:0]           irq_t;
  typedef logic [31:0]           addr_t;
  typedef logic [DBG_SETS_W-1:0] dbg_sets_t;

  //////////////////////////////////////////////////
  // handler classes
  //////////////////////////////////////////////////

  localparam pc_mux_t EXC_PC_IRQ     = 2'd0;
  localparam pc_mux_t EXC_PC_ECALL   = 2'd1;
  localparam pc_mux_t EXC_PC_ILLINSN = 2'd2;
  // load and store errors share one handler
  localparam pc_mux_t EXC_PC_LSU     = 2'd3;

  // byte distance between two handler slots
  localparam int unsigned PC_MUX_OFFSET_STEP = 16;

  // synchronous cause codes
  localparam cause_t CAUSE_ILLEGAL   = 6'd2;
  localparam cause_t CAUSE_LOAD_ERR  = 6'd5;
  localparam cause_t CAUSE_STORE_ERR = 6'd7;
  localparam cause_t CAUSE_ECALL     = 6'd8;

  // debug setting word, one bit per event class
  localparam int unsigned DBG_SETS_IRQ   = 0;
  localparam int unsigned DBG_SETS_ECALL = 1;
  localparam int unsigned DBG_SETS_EILL  = 2;
  localparam int unsigned DBG_SETS_ELSU  = 3;
  localparam int unsigned DBG_SETS_EBRK  = 4;
  localparam int unsigned DBG_SETS_SSTE  = 5;

endpackage
